// File: verilog/mips_addr_pkg.sv
package mips_addr_pkg;

    localparam int VADDR_W       = 32;
    localparam int PAGE_OFFSET_W = 12;

    // kseg0/kseg1 map straight onto the low 512 MB
    localparam logic [VADDR_W-1:0] UNMAPPED_MASK = 32'h1fff_ffff;

    typedef struct packed {
        logic [2:0]  seg_hi;
        logic [28:0] low;
    } seg_view_t;

    typedef struct packed {
        logic [18:0]              vpn2;
        logic                     odd;    // even/odd page of the pair
        logic [PAGE_OFFSET_W-1:0] offset;
    } page_view_t;

    // one address word, decoded by segment or by page
    typedef union packed {
        seg_view_t  seg;
        page_view_t page;
    } vaddr_u;

    typedef enum logic [1:0] {
        SEG_KUSEG,
        SEG_KSEG0,
        SEG_KSEG1,
        SEG_KSEG23
    } seg_t;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } exc_t;

endpackage

// File: verilog/mips_tlb_pkg.sv
package mips_tlb_pkg;

    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = 2;
    localparam int ASID_W      = 8;
    localparam int VPN2_W      = 19;
    localparam int PFN_W       = 20;
    localparam int ATTR_W      = 3;

    // EntryLo layout
    localparam int LO_PFN_HI = 25;
    localparam int LO_PFN_LO = 6;
    localparam int LO_C_HI   = 5;
    localparam int LO_C_LO   = 3;
    localparam int LO_D      = 2;
    localparam int LO_V      = 1;
    localparam int LO_G      = 0;

    // EntryHi layout
    localparam int HI_VPN2_HI = 31;
    localparam int HI_VPN2_LO = 13;
    localparam int HI_ASID_HI = 7;
    localparam int HI_ASID_LO = 0;

    localparam logic [ATTR_W-1:0] CACHE_CACHEABLE = 3'd3;

endpackage

// File: verilog/seg_decode.sv
`timescale 1ns/1ps

module seg_decode (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            i_req,
    input  logic [31:0]                     i_vaddr,
    input  logic                            i_write,
    input  logic [mips_tlb_pkg::ASID_W-1:0] i_asid,
    input  logic                            i_kernel_mode,
    output logic                            o_valid,
    output mips_addr_pkg::vaddr_u           o_vaddr,
    output logic                            o_write,
    output logic [mips_tlb_pkg::ASID_W-1:0] o_asid,
    output mips_addr_pkg::seg_t             o_seg,
    output logic                            o_addr_err
);

    mips_addr_pkg::vaddr_u va;
    mips_addr_pkg::seg_t   seg;
    logic                  addr_err;

    assign va = i_vaddr;

    always_comb begin
        if (!va.seg.seg_hi[2]) begin
            seg = mips_addr_pkg::SEG_KUSEG;    // 0x0000_0000 .. 0x7fff_ffff
        end else if (va.seg.seg_hi == 3'b100) begin
            seg = mips_addr_pkg::SEG_KSEG0;
        end else if (va.seg.seg_hi == 3'b101) begin
            seg = mips_addr_pkg::SEG_KSEG1;
        end else begin
            seg = mips_addr_pkg::SEG_KSEG23;
        end
    end

    // user mode may only touch kuseg
    assign addr_err = !i_kernel_mode && (seg != mips_addr_pkg::SEG_KUSEG);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_req;
        end
    end

    always_ff @(posedge aclk) begin
        o_vaddr    <= va;
        o_write    <= i_write;
        o_asid     <= i_asid;
        o_seg      <= seg;
        o_addr_err <= addr_err;
    end

endmodule

// File: verilog/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               i_valid,
    input  mips_addr_pkg::vaddr_u              i_vaddr,
    input  logic                               i_write,
    input  logic [mips_tlb_pkg::ASID_W-1:0]    i_asid,
    input  mips_addr_pkg::seg_t                i_seg,
    input  logic                               i_addr_err,
    input  logic                               i_tlb_we,
    input  logic [mips_tlb_pkg::TLB_IDX_W-1:0] i_tlb_index,
    input  logic [31:0]                        i_entry_hi,
    input  logic [31:0]                        i_entry_lo0,
    input  logic [31:0]                        i_entry_lo1,
    output logic                               o_valid,
    output mips_addr_pkg::vaddr_u              o_vaddr,
    output logic                               o_write,
    output mips_addr_pkg::seg_t                o_seg,
    output logic                               o_addr_err,
    output logic                               o_hit,
    output logic                               o_page_valid,
    output logic                               o_dirty,
    output logic [mips_tlb_pkg::PFN_W-1:0]     o_pfn,
    output logic [mips_tlb_pkg::ATTR_W-1:0]    o_attr
);

    localparam int N = mips_tlb_pkg::TLB_ENTRIES;

    // per entry tag, pages indexed by the odd bit
    logic [mips_tlb_pkg::VPN2_W-1:0] ent_vpn2 [N];
    logic [mips_tlb_pkg::ASID_W-1:0] ent_asid [N];
    logic                            ent_g    [N];
    logic [1:0]                      ent_v    [N];
    logic [1:0]                      ent_d    [N];
    logic [mips_tlb_pkg::PFN_W-1:0]  ent_pfn  [N][2];
    logic [mips_tlb_pkg::ATTR_W-1:0] ent_c    [N][2];

    logic                               mapped;
    logic                               match;
    logic [mips_tlb_pkg::TLB_IDX_W-1:0] hit_idx;
    logic                               hit;

    // valid and global bits
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < N; i++) begin
                ent_g[i] <= 1'b0;
                ent_v[i] <= 2'b00;
            end
        end else if (i_tlb_we) begin
            ent_g[i_tlb_index] <= i_entry_lo0[mips_tlb_pkg::LO_G] & i_entry_lo1[mips_tlb_pkg::LO_G];
            ent_v[i_tlb_index] <= {i_entry_lo1[mips_tlb_pkg::LO_V],
                                   i_entry_lo0[mips_tlb_pkg::LO_V]};
        end
    end

    always_ff @(posedge aclk) begin
        if (i_tlb_we) begin
            ent_vpn2[i_tlb_index] <=
                i_entry_hi[mips_tlb_pkg::HI_VPN2_HI:mips_tlb_pkg::HI_VPN2_LO];
            ent_asid[i_tlb_index] <=
                i_entry_hi[mips_tlb_pkg::HI_ASID_HI:mips_tlb_pkg::HI_ASID_LO];
            ent_d[i_tlb_index] <= {i_entry_lo1[mips_tlb_pkg::LO_D],
                                   i_entry_lo0[mips_tlb_pkg::LO_D]};
            ent_pfn[i_tlb_index][0] <=
                i_entry_lo0[mips_tlb_pkg::LO_PFN_HI:mips_tlb_pkg::LO_PFN_LO];
            ent_pfn[i_tlb_index][1] <=
                i_entry_lo1[mips_tlb_pkg::LO_PFN_HI:mips_tlb_pkg::LO_PFN_LO];
            ent_c[i_tlb_index][0] <= i_entry_lo0[mips_tlb_pkg::LO_C_HI:mips_tlb_pkg::LO_C_LO];
            ent_c[i_tlb_index][1] <= i_entry_lo1[mips_tlb_pkg::LO_C_HI:mips_tlb_pkg::LO_C_LO];
        end
    end

    // scan from the top so the lowest index wins
    always_comb begin
        match   = 1'b0;
        hit_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if ((ent_vpn2[i] == i_vaddr.page.vpn2) && (ent_g[i] || (ent_asid[i] == i_asid))) begin
                match   = 1'b1;
                hit_idx = mips_tlb_pkg::TLB_IDX_W'(i);
            end
        end
    end

    assign mapped = (i_seg == mips_addr_pkg::SEG_KUSEG) || (i_seg == mips_addr_pkg::SEG_KSEG23);
    assign hit    = mapped && match;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge aclk) begin
        o_vaddr      <= i_vaddr;
        o_write      <= i_write;
        o_seg        <= i_seg;
        o_addr_err   <= i_addr_err;
        o_hit        <= hit;
        o_page_valid <= hit && ent_v[hit_idx][i_vaddr.page.odd];
        o_dirty      <= hit && ent_d[hit_idx][i_vaddr.page.odd];
        o_pfn        <= ent_pfn[hit_idx][i_vaddr.page.odd];
        o_attr       <= ent_c[hit_idx][i_vaddr.page.odd];
    end

endmodule

// File: verilog/xlate_result.sv
`timescale 1ns/1ps

module xlate_result (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            i_valid,
    input  mips_addr_pkg::vaddr_u           i_vaddr,
    input  logic                            i_write,
    input  mips_addr_pkg::seg_t             i_seg,
    input  logic                            i_addr_err,
    input  logic                            i_hit,
    input  logic                            i_page_valid,
    input  logic                            i_dirty,
    input  logic [mips_tlb_pkg::PFN_W-1:0]  i_pfn,
    input  logic [mips_tlb_pkg::ATTR_W-1:0] i_attr,
    input  logic                            i_kseg0_cached,
    output logic                            o_valid,
    output logic [31:0]                     o_paddr,
    output logic                            o_cached,
    output mips_addr_pkg::exc_t             o_exc,
    output logic                            o_refill
);

    logic [31:0]         paddr;
    logic                cached;
    mips_addr_pkg::exc_t exc;
    logic                refill;
    logic                mapped;

    assign mapped = (i_seg == mips_addr_pkg::SEG_KUSEG) || (i_seg == mips_addr_pkg::SEG_KSEG23);

    always_comb begin
        paddr  = i_vaddr & mips_addr_pkg::UNMAPPED_MASK;
        cached = 1'b0;    // kseg1 stays uncached
        if (i_seg == mips_addr_pkg::SEG_KSEG0) begin
            cached = i_kseg0_cached;
        end else if (mapped) begin
            paddr  = {i_pfn, i_vaddr.page.offset};
            cached = (i_attr == mips_tlb_pkg::CACHE_CACHEABLE);
        end
    end

    always_comb begin
        exc    = mips_addr_pkg::EXC_NONE;
        refill = 1'b0;
        if (i_addr_err) begin
            if (i_write) begin
                exc = mips_addr_pkg::EXC_ADES;
            end else begin
                exc = mips_addr_pkg::EXC_ADEL;
            end
        end else if (mapped && (!i_hit || !i_page_valid)) begin
            refill = !i_hit;    // miss goes to the refill vector
            if (i_write) begin
                exc = mips_addr_pkg::EXC_TLBS;
            end else begin
                exc = mips_addr_pkg::EXC_TLBL;
            end
        end else if (mapped && i_write && !i_dirty) begin
            exc = mips_addr_pkg::EXC_MOD;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge aclk) begin
        o_paddr  <= paddr;
        o_cached <= cached;
        o_exc    <= exc;
        o_refill <= refill;
    end

endmodule

// File: verilog/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               i_req,
    input  logic [31:0]                        i_vaddr,
    input  logic                               i_write,
    input  logic [mips_tlb_pkg::ASID_W-1:0]    i_asid,
    input  logic                               i_kernel_mode,
    input  logic                               i_kseg0_cached,
    input  logic                               i_tlb_we,
    input  logic [mips_tlb_pkg::TLB_IDX_W-1:0] i_tlb_index,
    input  logic [31:0]                        i_entry_hi,
    input  logic [31:0]                        i_entry_lo0,
    input  logic [31:0]                        i_entry_lo1,
    output logic                               o_valid,
    output logic [31:0]                        o_paddr,
    output logic                               o_cached,
    output mips_addr_pkg::exc_t                o_exc,
    output logic                               o_refill
);

    // decode -> lookup
    logic                            d_valid;
    mips_addr_pkg::vaddr_u           d_vaddr;
    logic                            d_write;
    logic [mips_tlb_pkg::ASID_W-1:0] d_asid;
    mips_addr_pkg::seg_t             d_seg;
    logic                            d_addr_err;

    // lookup -> result
    logic                            l_valid;
    mips_addr_pkg::vaddr_u           l_vaddr;
    logic                            l_write;
    mips_addr_pkg::seg_t             l_seg;
    logic                            l_addr_err;
    logic                            l_hit;
    logic                            l_page_valid;
    logic                            l_dirty;
    logic [mips_tlb_pkg::PFN_W-1:0]  l_pfn;
    logic [mips_tlb_pkg::ATTR_W-1:0] l_attr;

    seg_decode u_decode (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_req         (i_req),
        .i_vaddr       (i_vaddr),
        .i_write       (i_write),
        .i_asid        (i_asid),
        .i_kernel_mode (i_kernel_mode),
        .o_valid       (d_valid),
        .o_vaddr       (d_vaddr),
        .o_write       (d_write),
        .o_asid        (d_asid),
        .o_seg         (d_seg),
        .o_addr_err    (d_addr_err)
    );

    tlb_lookup u_lookup (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_valid      (d_valid),
        .i_vaddr      (d_vaddr),
        .i_write      (d_write),
        .i_asid       (d_asid),
        .i_seg        (d_seg),
        .i_addr_err   (d_addr_err),
        .i_tlb_we     (i_tlb_we),
        .i_tlb_index  (i_tlb_index),
        .i_entry_hi   (i_entry_hi),
        .i_entry_lo0  (i_entry_lo0),
        .i_entry_lo1  (i_entry_lo1),
        .o_valid      (l_valid),
        .o_vaddr      (l_vaddr),
        .o_write      (l_write),
        .o_seg        (l_seg),
        .o_addr_err   (l_addr_err),
        .o_hit        (l_hit),
        .o_page_valid (l_page_valid),
        .o_dirty      (l_dirty),
        .o_pfn        (l_pfn),
        .o_attr       (l_attr)
    );

    xlate_result u_result (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_valid        (l_valid),
        .i_vaddr        (l_vaddr),
        .i_write        (l_write),
        .i_seg          (l_seg),
        .i_addr_err     (l_addr_err),
        .i_hit          (l_hit),
        .i_page_valid   (l_page_valid),
        .i_dirty        (l_dirty),
        .i_pfn          (l_pfn),
        .i_attr         (l_attr),
        .i_kseg0_cached (i_kseg0_cached),
        .o_valid        (o_valid),
        .o_paddr        (o_paddr),
        .o_cached       (o_cached),
        .o_exc          (o_exc),
        .o_refill       (o_refill)
    );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_aclk,
    output logic o_aresetn
);

    localparam int HALF_PERIOD = 4;    // 8 ns clock

    initial begin
        o_aclk = 1'b0;
        forever #HALF_PERIOD o_aclk = ~o_aclk;
    end

    // low for four rising edges, released on a falling edge
    initial begin
        o_aresetn = 1'b0;
        repeat (4) @(posedge o_aclk);
        @(negedge o_aclk);
        o_aresetn = 1'b1;
    end

endmodule

// File: verif/tb_mmu_top.sv
`timescale 1ns/1ps

module tb_mmu_top;

    localparam int   MAX_STEPS    = 64;
    localparam int   LATENCY      = 3;
    localparam logic RD   = 1'b0;
    localparam logic WR   = 1'b1;
    localparam logic USER = 1'b0;
    localparam logic KERN = 1'b1;

    logic        aclk;
    logic        aresetn;
    logic        i_req;
    logic [31:0] i_vaddr;
    logic        i_write;
    logic [7:0]  i_asid;
    logic        i_kernel_mode;
    logic        i_kseg0_cached;
    logic        i_tlb_we;
    logic [1:0]  i_tlb_index;
    logic [31:0] i_entry_hi;
    logic [31:0] i_entry_lo0;
    logic [31:0] i_entry_lo1;
    logic        o_valid;
    logic [31:0] o_paddr;
    logic        o_cached;
    logic        o_refill;
    mips_addr_pkg::exc_t o_exc;

    // step table with st_kind high for a TLB write
    logic                st_kind   [MAX_STEPS];
    logic [31:0]         st_a      [MAX_STEPS];    // vaddr or EntryHi
    logic [31:0]         st_lo0    [MAX_STEPS];
    logic [31:0]         st_lo1    [MAX_STEPS];
    logic [1:0]          st_idx    [MAX_STEPS];
    logic                st_write  [MAX_STEPS];
    logic [7:0]          st_asid   [MAX_STEPS];
    logic                st_kmode  [MAX_STEPS];
    logic                st_k0c    [MAX_STEPS];    // Config.K0 cacheable bit
    logic [31:0]         exp_paddr [MAX_STEPS];
    logic                exp_cached[MAX_STEPS];
    mips_addr_pkg::exc_t exp_exc   [MAX_STEPS];
    logic                exp_refill[MAX_STEPS];
    logic                exp_chk   [MAX_STEPS];    // paddr/cached defined
    int                  n_steps;

    // shadow TLB for the reference model
    logic [31:0] m_hi [4];
    logic [31:0] m_lo0[4];
    logic [31:0] m_lo1[4];
    logic        m_written[4];
    logic        k0_cached;

    logic [31:0] rng_state;
    int          pend_step[$];
    int          pend_cyc[$];
    int          cyc;

    tb_clk_gen u_clk (
        .o_aclk    (aclk),
        .o_aresetn (aresetn)
    );

    mmu_top dut (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_req          (i_req),
        .i_vaddr        (i_vaddr),
        .i_write        (i_write),
        .i_asid         (i_asid),
        .i_kernel_mode  (i_kernel_mode),
        .i_kseg0_cached (i_kseg0_cached),
        .i_tlb_we       (i_tlb_we),
        .i_tlb_index    (i_tlb_index),
        .i_entry_hi     (i_entry_hi),
        .i_entry_lo0    (i_entry_lo0),
        .i_entry_lo1    (i_entry_lo1),
        .o_valid        (o_valid),
        .o_paddr        (o_paddr),
        .o_cached       (o_cached),
        .o_exc          (o_exc),
        .o_refill       (o_refill)
    );

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "wrong value from the DUT");
    endtask

    task automatic fail_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "testbench stopped");
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] make_hi(input logic [31:0] va, input logic [7:0] asid);
        return {va[31:13], 5'b0, asid};
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    task automatic model_translate(input logic [31:0] va, input logic wr,
                                   input logic [7:0] asid, input logic km,
                                   input logic k0c,
                                   output logic [31:0] pa, output logic ca,
                                   output mips_addr_pkg::exc_t exc,
                                   output logic rf, output logic chk);
        logic        kuseg;
        logic        kseg0;
        logic        mapped;
        logic        adr_err;
        logic        hit;
        logic        glob;
        logic [31:0] lo;
        int          hit_i;
        kuseg   = !va[31];
        kseg0   = (va[31:29] == 3'b100);
        mapped  = kuseg || (va[31:30] == 2'b11);
        adr_err = !km && !kuseg;
        hit     = 1'b0;
        hit_i   = 0;
        for (int i = 0; i < 4; i++) begin
            glob = m_lo0[i][0] & m_lo1[i][0];
            if (!hit && m_written[i] && (m_hi[i][31:13] == va[31:13]) &&
                (glob || (m_hi[i][7:0] == asid))) begin
                hit   = 1'b1;
                hit_i = i;
            end
        end
        lo  = va[12] ? m_lo1[hit_i] : m_lo0[hit_i];
        pa  = va & 32'h1fff_ffff;
        ca  = kseg0 ? k0c : 1'b0;
        chk = 1'b1;
        if (mapped) begin
            pa  = {lo[25:6], va[11:0]};
            ca  = (lo[5:3] == 3'd3);
            chk = hit;    // a miss leaves the address undefined
        end
        exc = mips_addr_pkg::EXC_NONE;
        rf  = 1'b0;
        if (adr_err) begin
            exc = wr ? mips_addr_pkg::EXC_ADES : mips_addr_pkg::EXC_ADEL;
        end else if (mapped && (!hit || !lo[1])) begin
            exc = wr ? mips_addr_pkg::EXC_TLBS : mips_addr_pkg::EXC_TLBL;
            rf  = !hit;
        end else if (mapped && wr && !lo[2]) begin
            exc = mips_addr_pkg::EXC_MOD;
        end
    endtask

    task automatic add_tlb_write(input logic [1:0] idx, input logic [31:0] hi,
                                 input logic [31:0] lo0, input logic [31:0] lo1);
        assert (n_steps < MAX_STEPS) else fail_run("step table is full");
        st_kind[n_steps] = 1'b1;
        st_idx[n_steps]  = idx;
        st_a[n_steps]    = hi;
        st_lo0[n_steps]  = lo0;
        st_lo1[n_steps]  = lo1;
        st_k0c[n_steps]  = k0_cached;
        m_hi[idx]        = hi;
        m_lo0[idx]       = lo0;
        m_lo1[idx]       = lo1;
        m_written[idx]   = 1'b1;
        n_steps++;
    endtask

    task automatic add_request(input logic [31:0] base, input logic wr,
                               input logic [7:0] asid, input logic km);
        logic [31:0] va;
        int          s;
        assert (n_steps < MAX_STEPS) else fail_run("step table is full");
        s           = n_steps;
        va          = base | (next_random() & 32'h0000_0fff);
        st_kind[s]  = 1'b0;
        st_a[s]     = va;
        st_write[s] = wr;
        st_asid[s]  = asid;
        st_kmode[s] = km;
        st_k0c[s]   = k0_cached;
        model_translate(va, wr, asid, km, k0_cached, exp_paddr[s], exp_cached[s],
                        exp_exc[s], exp_refill[s], exp_chk[s]);
        n_steps++;
    endtask

    task automatic build_table();
        k0_cached = 1'b1;
        // unmapped windows and then user mode outside kuseg
        add_request(32'h8000_0000, RD, 8'h00, KERN);
        add_request(32'h8123_4000, WR, 8'h00, KERN);
        add_request(32'ha000_0000, RD, 8'h00, KERN);
        add_request(32'hbfff_f000, WR, 8'h00, KERN);
        add_request(32'h8000_0000, RD, 8'h05, USER);
        add_request(32'ha010_0000, WR, 8'h05, USER);
        add_request(32'hc000_0000, RD, 8'h05, USER);
        add_request(32'he000_0000, WR, 8'h05, USER);
        k0_cached = 1'b0;    // K0 changes with no kseg0 request in flight
        // every entry written before any mapped lookup
        add_tlb_write(2'd0, make_hi(32'h0040_0000, 8'h05),
                      make_lo(20'h12345, 3'd3, 1'b1, 1'b1, 1'b0),
                      make_lo(20'h0abcd, 3'd2, 1'b0, 1'b1, 1'b0));
        add_tlb_write(2'd1, make_hi(32'h0060_0000, 8'h77),
                      make_lo(20'h00100, 3'd3, 1'b1, 1'b1, 1'b1),
                      make_lo(20'h00101, 3'd3, 1'b1, 1'b0, 1'b1));
        add_tlb_write(2'd2, make_hi(32'hc000_0000, 8'h05),
                      make_lo(20'h7ffff, 3'd3, 1'b1, 1'b1, 1'b1),
                      make_lo(20'h00042, 3'd2, 1'b1, 1'b1, 1'b1));
        add_tlb_write(2'd3, make_hi(32'h0040_0000, 8'h09),
                      make_lo(20'h55555, 3'd3, 1'b1, 1'b1, 1'b0),
                      make_lo(20'h55556, 3'd3, 1'b1, 1'b1, 1'b0));
        add_request(32'h0040_0000, RD, 8'h05, USER);
        add_request(32'h0040_1000, WR, 8'h05, USER);    // clean odd page
        add_request(32'h0040_1000, RD, 8'h05, USER);
        add_request(32'h0040_0000, RD, 8'h09, USER);    // skips idx0 on asid
        add_request(32'h0040_0000, RD, 8'h33, USER);
        add_request(32'h0040_1000, WR, 8'h33, USER);
        add_request(32'h0060_0000, RD, 8'h33, USER);    // global entry
        add_request(32'h0060_0000, WR, 8'h01, KERN);
        add_request(32'h0060_1000, RD, 8'h33, USER);
        add_request(32'h0060_1000, WR, 8'h33, USER);
        add_request(32'hc000_0000, RD, 8'h12, KERN);
        add_request(32'hc000_1000, WR, 8'h12, KERN);
        add_request(32'hc010_0000, RD, 8'h12, KERN);
        add_request(32'hc010_0000, WR, 8'h12, KERN);
        add_request(32'hc000_0000, RD, 8'h12, USER);
        // later requests see the rewritten idx0
        add_tlb_write(2'd0, make_hi(32'h0040_0000, 8'h05),
                      make_lo(20'h0beef, 3'd3, 1'b1, 1'b1, 1'b0),
                      make_lo(20'h0beee, 3'd3, 1'b1, 1'b0, 1'b0));
        add_request(32'h0040_0000, RD, 8'h05, USER);
        add_request(32'h0040_1000, WR, 8'h05, USER);
        add_request(32'h0040_0000, WR, 8'h05, KERN);
        add_request(32'h9000_0000, RD, 8'h05, KERN);
        add_request(32'hb000_0000, WR, 8'h05, KERN);
    endtask

    task automatic drive_idle();
        i_req    = 1'b0;
        i_tlb_we = 1'b0;
    endtask

    // checks the outputs at a falling edge before the caller drives
    task automatic tick();
        int s;
        int issued;
        @(negedge aclk);
        cyc++;
        if (o_valid) begin
            assert (pend_step.size() != 0) else fail_run("o_valid high with no request in flight");
            s      = pend_step.pop_front();
            issued = pend_cyc.pop_front();
            assert (cyc - issued == LATENCY)
                else report_mismatch($sformatf("step %0d result after %0d cycles", s, cyc - issued));
            assert (o_exc == exp_exc[s])
                else report_mismatch($sformatf("step %0d exc %0d expected %0d",
                                               s, o_exc, exp_exc[s]));
            assert (o_refill == exp_refill[s])
                else report_mismatch($sformatf("step %0d refill %0b", s, o_refill));
            if (exp_chk[s]) begin
                assert (o_paddr == exp_paddr[s])
                    else report_mismatch($sformatf("step %0d paddr %h expected %h",
                                                   s, o_paddr, exp_paddr[s]));
                assert (o_cached == exp_cached[s])
                    else report_mismatch($sformatf("step %0d cached %0b", s, o_cached));
            end
        end else if (pend_step.size() != 0) begin
            assert (cyc - pend_cyc[0] < LATENCY)
                else fail_run($sformatf("no result for step %0d in time", pend_step[0]));
        end
    endtask

    initial begin
        int wait_cnt;
        i_req          = 1'b0;
        i_vaddr        = '0;
        i_write        = 1'b0;
        i_asid         = '0;
        i_kernel_mode  = 1'b0;
        i_kseg0_cached = 1'b0;
        i_tlb_we       = 1'b0;
        i_tlb_index    = '0;
        i_entry_hi     = '0;
        i_entry_lo0    = '0;
        i_entry_lo1    = '0;
        rng_state      = 32'd14997;
        n_steps        = 0;
        cyc            = 0;
        for (int i = 0; i < 4; i++) begin
            m_written[i] = 1'b0;
        end
        build_table();

        wait_cnt = 0;
        while (aresetn !== 1'b1) begin
            tick();
            wait_cnt++;
            assert (wait_cnt < 20) else fail_run("reset was never released");
        end
        repeat (3) tick();    // o_valid must stay low here

        for (int s = 0; s < n_steps; s++) begin
            tick();
            drive_idle();
            i_kseg0_cached = st_k0c[s];
            if (st_kind[s]) begin
                i_tlb_we    = 1'b1;
                i_tlb_index = st_idx[s];
                i_entry_hi  = st_a[s];
                i_entry_lo0 = st_lo0[s];
                i_entry_lo1 = st_lo1[s];
            end else begin
                i_req         = 1'b1;
                i_vaddr       = st_a[s];
                i_write       = st_write[s];
                i_asid        = st_asid[s];
                i_kernel_mode = st_kmode[s];
                pend_step.push_back(s);
                pend_cyc.push_back(cyc);
            end
        end
        tick();
        drive_idle();

        wait_cnt = 0;
        while (pend_step.size() != 0) begin
            tick();
            wait_cnt++;
            assert (wait_cnt < 10) else fail_run("pipeline did not drain");
        end
        repeat (3) tick();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: filelist.f
verilog/mips_addr_pkg.sv
verilog/mips_tlb_pkg.sv
verilog/seg_decode.sv
verilog/tlb_lookup.sv
verilog/xlate_result.sv
verilog/mmu_top.sv
verif/tb_clk_gen.sv
verif/tb_mmu_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the MMU testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_mmu_top -Mdir obj_dir -o sim_mmu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mmu
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
